//--- hdl/la_pkg.sv
`default_nettype none

package la_pkg;

    // one instruction word seen through the three fixed field layouts
    typedef struct packed {
        logic [16:0] op;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } r_fmt_t;

    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] i12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } i12_fmt_t;

    typedef struct packed {
        logic [6:0]  op;
        logic [19:0] i20;
        logic [4:0]  rd;
    } i20_fmt_t;

    typedef union packed {
        r_fmt_t   r_fmt;
        i12_fmt_t i12_fmt;
        i20_fmt_t i20_fmt;
    } inst_word_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic        rf_we;
        logic [4:0]  dest;
        logic        illegal;
        logic [31:0] pc;
    } id_to_ex_t;

    typedef struct packed {
        logic        rf_we;
        logic [4:0]  dest;
        logic [31:0] wdata;
        logic        illegal;
        logic [31:0] pc;
    } ex_to_wb_t;

    // bypass value offered to decode by a later stage
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } fwd_t;

endpackage

`default_nettype wire

//--- hdl/la_regfile.sv
`default_nettype none

module la_regfile (
    input  wire         clk,
    input  wire  [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  wire  [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  wire         we,
    input  wire  [4:0]  waddr,
    input  wire  [31:0] wdata
);
    logic [31:0] regs [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, r0 tied to zero
    always_comb begin
        rdata1 = 32'd0;
        rdata2 = 32'd0;
        if (raddr1 != 5'd0) begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 != 5'd0) begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

//--- hdl/la_alu.sv
`default_nettype none

module la_alu
    import la_pkg::*;
(
    input  wire alu_op_t     op,
    input  wire  [31:0]      a,
    input  wire  [31:0]      b,
    output logic [31:0]      y
);
    logic        sub_mode;
    logic [31:0] b_in;
    logic [31:0] g;
    logic [31:0] p;
    logic [32:0] c;
    logic [31:0] sum;
    logic        lt_signed;
    logic        lt_unsigned;

    // sub, slt and sltu all use a + ~b + 1
    assign sub_mode = op == ALU_SUB || op == ALU_SLT || op == ALU_SLTU;
    assign b_in     = sub_mode ? ~b : b;
    assign g        = a & b_in;
    assign p        = a ^ b_in;
    assign c[0]     = sub_mode;

    // 4-bit lookahead groups, group carries ripple
    for (genvar k = 0; k < 8; k++) begin : g_cla
        localparam int B = 4 * k;
        assign c[B+1] = g[B] | (p[B] & c[B]);
        assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & c[B]);
        assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B])
                      | (p[B+2] & p[B+1] & p[B] & c[B]);
        assign c[B+4] = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1])
                      | (p[B+3] & p[B+2] & p[B+1] & g[B])
                      | (p[B+3] & p[B+2] & p[B+1] & p[B] & c[B]);
    end

    assign sum = p ^ c[31:0];

    // signs differ: a negative wins, else sign of the difference
    assign lt_signed   = (a[31] & ~b[31]) | (~(a[31] ^ b[31]) & sum[31]);
    assign lt_unsigned = ~c[32];

    always_comb begin
        case (op)
            ALU_ADD,
            ALU_SUB:  y = sum;
            ALU_SLT:  y = {31'd0, lt_signed};
            ALU_SLTU: y = {31'd0, lt_unsigned};
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_NOR:  y = ~(a | b);
            ALU_XOR:  y = a ^ b;
            ALU_SLL:  y = a << b[4:0];
            ALU_SRL:  y = a >> b[4:0];
            ALU_SRA:  y = $unsigned($signed(a) >>> b[4:0]);
            default:  y = b;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/la_decode_stage.sv
`default_nettype none

module la_decode_stage
    import la_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,
    input  wire             inst_valid,
    input  wire inst_word_t inst,
    input  wire  [31:0]     pc,
    output logic            inst_allowin,
    output logic [4:0]      rf_raddr1,
    output logic [4:0]      rf_raddr2,
    input  wire  [31:0]     rf_rdata1,
    input  wire  [31:0]     rf_rdata2,
    input  wire fwd_t       ex_fwd,
    input  wire fwd_t       wb_fwd,
    input  wire             ex_allowin,
    output logic            id_to_ex_valid,
    output id_to_ex_t       id_to_ex
);
    logic        id_valid;
    inst_word_t  id_inst;
    logic [31:0] id_pc;

    logic        legal;
    alu_op_t     alu_op;
    logic        need_si12;
    logic        need_ui12;
    logic        need_ui5;
    logic        need_i20;
    logic        src2_is_imm;
    logic [31:0] imm;
    logic [31:0] rj_value;
    logic [31:0] rk_value;

    function automatic logic fwd_hit(input fwd_t f, input logic [4:0] addr);
        return f.valid && f.we && f.waddr == addr && addr != 5'd0;
    endfunction

    // execute first, then result, then the register file
    function automatic logic [31:0] pick_operand(
        input logic [4:0]  addr,
        input logic [31:0] rf_value,
        input fwd_t        ex_f,
        input fwd_t        wb_f
    );
        if (fwd_hit(ex_f, addr)) begin
            return ex_f.wdata;
        end
        if (fwd_hit(wb_f, addr)) begin
            return wb_f.wdata;
        end
        return rf_value;
    endfunction

    // single-cycle execute, so decode never holds back on its own
    assign inst_allowin   = !id_valid || ex_allowin;
    assign id_to_ex_valid = id_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (inst_allowin) begin
            id_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_allowin) begin
            id_inst <= inst;
            id_pc   <= pc;
        end
    end

    // opcode spaces of the three formats do not overlap
    always_comb begin
        alu_op    = ALU_ADD;
        legal     = 1'b1;
        need_si12 = 1'b0;
        need_ui12 = 1'b0;
        need_ui5  = 1'b0;
        need_i20  = 1'b0;
        case (id_inst.r_fmt.op)
            17'h00020: alu_op = ALU_ADD;
            17'h00022: alu_op = ALU_SUB;
            17'h00024: alu_op = ALU_SLT;
            17'h00025: alu_op = ALU_SLTU;
            17'h00028: alu_op = ALU_NOR;
            17'h00029: alu_op = ALU_AND;
            17'h0002a: alu_op = ALU_OR;
            17'h0002b: alu_op = ALU_XOR;
            17'h0002e: alu_op = ALU_SLL;
            17'h0002f: alu_op = ALU_SRL;
            17'h00030: alu_op = ALU_SRA;
            // slli.w, srli.w, srai.w carry ui5 in the rk slot
            17'h00081: begin
                alu_op   = ALU_SLL;
                need_ui5 = 1'b1;
            end
            17'h00089: begin
                alu_op   = ALU_SRL;
                need_ui5 = 1'b1;
            end
            17'h00091: begin
                alu_op   = ALU_SRA;
                need_ui5 = 1'b1;
            end
            default: begin
                need_si12 = 1'b1;
                case (id_inst.i12_fmt.op)
                    10'h008: alu_op = ALU_SLT;
                    10'h009: alu_op = ALU_SLTU;
                    10'h00a: alu_op = ALU_ADD;
                    10'h00d: alu_op = ALU_AND;
                    10'h00e: alu_op = ALU_OR;
                    10'h00f: alu_op = ALU_XOR;
                    default: begin
                        need_si12 = 1'b0;
                        // lu12i.w
                        if (id_inst.i20_fmt.op == 7'h0a) begin
                            alu_op   = ALU_LUI;
                            need_i20 = 1'b1;
                        end else begin
                            legal = 1'b0;
                        end
                    end
                endcase
                // logic immediates are zero extended
                if (id_inst.i12_fmt.op inside {10'h00d, 10'h00e, 10'h00f}) begin
                    need_si12 = 1'b0;
                    need_ui12 = 1'b1;
                end
            end
        endcase
    end

    assign src2_is_imm = need_si12 || need_ui12 || need_ui5 || need_i20;

    assign imm = need_i20  ? {id_inst.i20_fmt.i20, 12'd0} :
                 need_ui12 ? {20'd0, id_inst.i12_fmt.i12} :
                 need_ui5  ? {27'd0, id_inst.r_fmt.rk} :
                             {{20{id_inst.i12_fmt.i12[11]}}, id_inst.i12_fmt.i12};

    assign rf_raddr1 = id_inst.r_fmt.rj;
    assign rf_raddr2 = id_inst.r_fmt.rk;
    assign rj_value  = pick_operand(rf_raddr1, rf_rdata1, ex_fwd, wb_fwd);
    assign rk_value  = pick_operand(rf_raddr2, rf_rdata2, ex_fwd, wb_fwd);

    always_comb begin
        id_to_ex.alu_op  = alu_op;
        id_to_ex.src1    = rj_value;
        id_to_ex.src2    = src2_is_imm ? imm : rk_value;
        id_to_ex.rf_we   = legal;
        id_to_ex.dest    = id_inst.r_fmt.rd;
        id_to_ex.illegal = !legal;
        id_to_ex.pc      = id_pc;
    end

    // a stalled item keeps its operands, the stages behind are frozen too
    a_hold_stable : assert property (@(posedge clk) disable iff (!resetn)
        id_to_ex_valid && !ex_allowin |=> id_to_ex_valid && $stable(id_to_ex));

endmodule

`default_nettype wire

//--- hdl/la_execute_stage.sv
`default_nettype none

module la_execute_stage
    import la_pkg::*;
(
    input  wire            clk,
    input  wire            resetn,
    input  wire            id_to_ex_valid,
    input  wire id_to_ex_t id_to_ex,
    output logic           ex_allowin,
    output fwd_t           ex_fwd,
    input  wire            wb_allowin,
    output logic           ex_to_wb_valid,
    output ex_to_wb_t      ex_to_wb
);
    logic        ex_valid;
    id_to_ex_t   ex_reg;
    logic [31:0] alu_y;

    assign ex_allowin     = !ex_valid || wb_allowin;
    assign ex_to_wb_valid = ex_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= id_to_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_ex_valid && ex_allowin) begin
            ex_reg <= id_to_ex;
        end
    end

    la_alu alu_i (
        .op (ex_reg.alu_op),
        .a  (ex_reg.src1),
        .b  (ex_reg.src2),
        .y  (alu_y)
    );

    assign ex_to_wb.rf_we   = ex_reg.rf_we;
    assign ex_to_wb.dest    = ex_reg.dest;
    assign ex_to_wb.wdata   = alu_y;
    assign ex_to_wb.illegal = ex_reg.illegal;
    assign ex_to_wb.pc      = ex_reg.pc;

    // live result that decode can use in the same cycle
    assign ex_fwd.valid = ex_valid;
    assign ex_fwd.we    = ex_reg.rf_we;
    assign ex_fwd.waddr = ex_reg.dest;
    assign ex_fwd.wdata = alu_y;

    // the bypass value must not move while result holds us back
    a_fwd_hold : assert property (@(posedge clk) disable iff (!resetn)
        ex_valid && !wb_allowin |=> ex_fwd.valid && $stable(ex_fwd));

endmodule

`default_nettype wire

//--- hdl/la_result_stage.sv
`default_nettype none

module la_result_stage
    import la_pkg::*;
(
    input  wire            clk,
    input  wire            resetn,
    input  wire            ex_to_wb_valid,
    input  wire ex_to_wb_t ex_to_wb,
    output logic           wb_allowin,
    output fwd_t           wb_fwd,
    output logic           rf_we,
    output logic [4:0]     rf_waddr,
    output logic [31:0]    rf_wdata,
    input  wire            commit_ready,
    output logic           commit_valid,
    output logic           commit_we,
    output logic [4:0]     commit_dest,
    output logic [31:0]    commit_wdata,
    output logic [31:0]    commit_pc,
    output logic           commit_illegal
);
    logic      wb_valid;
    ex_to_wb_t wb_reg;

    assign wb_allowin   = !wb_valid || commit_ready;
    assign commit_valid = wb_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= ex_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_wb_valid && wb_allowin) begin
            wb_reg <= ex_to_wb;
        end
    end

    // regfile write only on the commit edge
    assign rf_we    = wb_valid && commit_ready && wb_reg.rf_we;
    assign rf_waddr = wb_reg.dest;
    assign rf_wdata = wb_reg.wdata;

    assign wb_fwd.valid = wb_valid;
    assign wb_fwd.we    = wb_reg.rf_we;
    assign wb_fwd.waddr = wb_reg.dest;
    assign wb_fwd.wdata = wb_reg.wdata;

    assign commit_we      = wb_reg.rf_we;
    assign commit_dest    = wb_reg.dest;
    assign commit_wdata   = wb_reg.wdata;
    assign commit_pc      = wb_reg.pc;
    assign commit_illegal = wb_reg.illegal;

    a_commit_hold : assert property (@(posedge clk) disable iff (!resetn)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_pc)
            && $stable(commit_we) && $stable(commit_dest) && $stable(commit_wdata)
            && $stable(commit_illegal));

endmodule

`default_nettype wire

//--- hdl/la_int_pipe.sv
`default_nettype none

module la_int_pipe
    import la_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,
    input  wire             inst_valid,
    input  wire inst_word_t inst,
    input  wire  [31:0]     pc,
    output logic            inst_allowin,
    input  wire             commit_ready,
    output logic            commit_valid,
    output logic            commit_we,
    output logic [4:0]      commit_dest,
    output logic [31:0]     commit_wdata,
    output logic [31:0]     commit_pc,
    output logic            commit_illegal
);
    logic        id_to_ex_valid;
    id_to_ex_t   id_to_ex;
    logic        ex_allowin;
    logic        ex_to_wb_valid;
    ex_to_wb_t   ex_to_wb;
    logic        wb_allowin;
    fwd_t        ex_fwd;
    fwd_t        wb_fwd;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    la_decode_stage decode_i (
        .clk            (clk),
        .resetn         (resetn),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .inst_allowin   (inst_allowin),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .ex_fwd         (ex_fwd),
        .wb_fwd         (wb_fwd),
        .ex_allowin     (ex_allowin),
        .id_to_ex_valid (id_to_ex_valid),
        .id_to_ex       (id_to_ex)
    );

    la_execute_stage execute_i (
        .clk            (clk),
        .resetn         (resetn),
        .id_to_ex_valid (id_to_ex_valid),
        .id_to_ex       (id_to_ex),
        .ex_allowin     (ex_allowin),
        .ex_fwd         (ex_fwd),
        .wb_allowin     (wb_allowin),
        .ex_to_wb_valid (ex_to_wb_valid),
        .ex_to_wb       (ex_to_wb)
    );

    la_result_stage result_i (
        .clk            (clk),
        .resetn         (resetn),
        .ex_to_wb_valid (ex_to_wb_valid),
        .ex_to_wb       (ex_to_wb),
        .wb_allowin     (wb_allowin),
        .wb_fwd         (wb_fwd),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .commit_ready   (commit_ready),
        .commit_valid   (commit_valid),
        .commit_we      (commit_we),
        .commit_dest    (commit_dest),
        .commit_wdata   (commit_wdata),
        .commit_pc      (commit_pc),
        .commit_illegal (commit_illegal)
    );

    la_regfile regfile_i (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

`default_nettype wire

//--- sim/la_commit_checker.sv
`default_nettype none

module la_commit_checker
    import la_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,
    input  wire             inst_valid,
    input  wire inst_word_t inst,
    input  wire  [31:0]     pc,
    input  wire             inst_allowin,
    input  wire             commit_ready,
    input  wire             commit_valid,
    input  wire             commit_we,
    input  wire  [4:0]      commit_dest,
    input  wire  [31:0]     commit_wdata,
    input  wire  [31:0]     commit_pc,
    input  wire             commit_illegal,
    output int              accepted_count,
    output int              commit_count,
    output int              mismatch_count,
    output int              error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic        we;
        logic [4:0]  dest;
        logic [31:0] wdata;
        logic        illegal;
    } exp_t;

    inst_word_t  inst_q [$];
    logic [31:0] pc_q [$];
    logic [31:0] model_rf [32];

    // architectural result of one instruction with a as the rj value and b as the rk value
    function automatic exp_t predict_commit(input inst_word_t w, input logic [31:0] a,
                                            input logic [31:0] b);
        exp_t        e;
        logic [31:0] si12;
        logic [31:0] ui12;
        logic [4:0]  sa;
        si12      = {{20{w.i12_fmt.i12[11]}}, w.i12_fmt.i12};
        ui12      = {20'd0, w.i12_fmt.i12};
        sa        = w.r_fmt.rk;
        e.we      = 1'b1;
        e.dest    = w.r_fmt.rd;
        e.wdata   = 32'd0;
        e.illegal = 1'b0;
        if (w.i20_fmt.op == 7'h0a) begin
            e.wdata = {w.i20_fmt.i20, 12'd0};
        end else begin
            case (w.i12_fmt.op)
                10'h008: e.wdata = {31'd0, $signed(a) < $signed(si12)};
                10'h009: e.wdata = {31'd0, a < si12};
                10'h00a: e.wdata = a + si12;
                10'h00d: e.wdata = a & ui12;
                10'h00e: e.wdata = a | ui12;
                10'h00f: e.wdata = a ^ ui12;
                default: begin
                    case (w.r_fmt.op)
                        17'h00020: e.wdata = a + b;
                        17'h00022: e.wdata = a - b;
                        17'h00024: e.wdata = {31'd0, $signed(a) < $signed(b)};
                        17'h00025: e.wdata = {31'd0, a < b};
                        17'h00028: e.wdata = ~(a | b);
                        17'h00029: e.wdata = a & b;
                        17'h0002a: e.wdata = a | b;
                        17'h0002b: e.wdata = a ^ b;
                        17'h0002e: e.wdata = a << b[4:0];
                        17'h0002f: e.wdata = a >> b[4:0];
                        17'h00030: e.wdata = 32'($signed(a) >>> b[4:0]);
                        17'h00081: e.wdata = a << sa;
                        17'h00089: e.wdata = a >> sa;
                        17'h00091: e.wdata = 32'($signed(a) >>> sa);
                        default: begin
                            e.we      = 1'b0;
                            e.illegal = 1'b1;
                        end
                    endcase
                end
            endcase
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_count = mismatch_count + 1;
        end
    endtask

    always @(posedge clk) begin : compare
        inst_word_t  w;
        logic [31:0] exp_pc;
        exp_t        e;
        if (!resetn) begin
            inst_q.delete();
            pc_q.delete();
            for (int i = 0; i < 32; i++) begin
                model_rf[i] = 32'd0;
            end
            accepted_count <= 0;
            commit_count   <= 0;
            mismatch_count = 0;
            error_count    = 0;
        end else begin
            if (inst_valid && inst_allowin) begin
                inst_q.push_back(inst);
                pc_q.push_back(pc);
                accepted_count <= accepted_count + 1;
            end
            if (commit_valid && commit_ready) begin
                commit_count <= commit_count + 1;
                if (inst_q.size() == 0) begin
                    $display("ERROR at %0t: commit of pc %h with no accepted instruction left",
                             $time, commit_pc);
                    error_count = error_count + 1;
                end else begin
                    w      = inst_q.pop_front();
                    exp_pc = pc_q.pop_front();
                    e      = predict_commit(w, model_rf[w.r_fmt.rj], model_rf[w.r_fmt.rk]);
                    check_value("commit_pc", commit_pc, exp_pc);
                    check_value("commit_illegal", 32'(commit_illegal), 32'(e.illegal));
                    check_value("commit_we", 32'(commit_we), 32'(e.we));
                    if (!e.illegal) begin
                        check_value("commit_dest", 32'(commit_dest), 32'(e.dest));
                        check_value("commit_wdata", commit_wdata, e.wdata);
                        // r0 stays zero in the model
                        if (e.dest != 5'd0) begin
                            model_rf[e.dest] = e.wdata;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_la_int_pipe.sv
`default_nettype none

module tb_la_int_pipe import la_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 8 + 100;

    // register-form opcodes, the last three carry ui5 in the rk slot
    localparam logic [16:0] REG_OPS [14] = '{
        17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028, 17'h00029, 17'h0002a,
        17'h0002b, 17'h0002e, 17'h0002f, 17'h00030, 17'h00081, 17'h00089, 17'h00091
    };
    localparam logic [9:0] IMM_OPS [6] = '{
        10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f
    };

    logic        clk;
    logic        resetn;
    logic        inst_valid;
    inst_word_t  inst;
    logic [31:0] pc;
    logic        inst_allowin;
    logic        commit_ready;
    logic        commit_valid;
    logic        commit_we;
    logic [4:0]  commit_dest;
    logic [31:0] commit_wdata;
    logic [31:0] commit_pc;
    logic        commit_illegal;
    int          accepted_count;
    int          commit_count;
    int          mismatch_count;
    int          error_count;
    int          run_errors;
    logic [31:0] lcg_state;

    la_int_pipe la_int_pipe_i (
        .clk            (clk),
        .resetn         (resetn),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .inst_allowin   (inst_allowin),
        .commit_ready   (commit_ready),
        .commit_valid   (commit_valid),
        .commit_we      (commit_we),
        .commit_dest    (commit_dest),
        .commit_wdata   (commit_wdata),
        .commit_pc      (commit_pc),
        .commit_illegal (commit_illegal)
    );

    la_commit_checker commit_checker_i (
        .clk            (clk),
        .resetn         (resetn),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .inst_allowin   (inst_allowin),
        .commit_ready   (commit_ready),
        .commit_valid   (commit_valid),
        .commit_we      (commit_we),
        .commit_dest    (commit_dest),
        .commit_wdata   (commit_wdata),
        .commit_pc      (commit_pc),
        .commit_illegal (commit_illegal),
        .accepted_count (accepted_count),
        .commit_count   (commit_count),
        .mismatch_count (mismatch_count),
        .error_count    (error_count)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // weak low bits rotated to the top
        return {lcg_state[7:0], lcg_state[31:8]};
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    function automatic inst_word_t make_inst(input int idx);
        inst_word_t  w;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        int          pick;
        // small register pool keeps dependencies dense
        rd   = 5'(rand_below(8));
        rj   = 5'(rand_below(8));
        rk   = 5'(rand_below(8));
        r    = next_rand();
        pick = rand_below(100);
        if (idx < 7) begin
            // lu12i.w seeds r1..r7 before anything reads them
            w = {7'h0a, r[19:0], 5'(idx + 1)};
        end else if (pick < 3) begin
            // outside all three opcode spaces
            w = {6'h3f, r[25:0]};
        end else begin
            pick = rand_below(21);
            if (pick >= 11 && pick < 14) begin
                rk = r[4:0];
            end
            if (pick < 14) begin
                w = {REG_OPS[pick], rk, rj, rd};
            end else if (pick < 20) begin
                w = {IMM_OPS[pick - 14], r[11:0], rj, rd};
            end else begin
                w = {7'h0a, r[19:0], rd};
            end
        end
        return w;
    endfunction

    task automatic finish_run(input logic timed_out);
        int other;
        other = error_count + run_errors + (timed_out ? 1 : 0);
        $display("summary: %0d accepted, %0d committed, %0d mismatches, %0d other errors",
                 accepted_count, commit_count, mismatch_count, other);
        if (mismatch_count == 0 && other == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : stimulus
        int          sent;
        logic [31:0] pc_next;
        lcg_state    = 32'd85358;
        resetn       = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        pc           = '0;
        commit_ready = 1'b0;
        run_errors   = 0;
        sent         = 0;
        pc_next      = 32'h1c00_0000;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        while (sent < NUM_INSTS) begin
            @(posedge clk);
            commit_ready <= rand_below(100) >= 30;
            if (inst_valid && inst_allowin) begin
                sent    = sent + 1;
                pc_next = pc_next + 32'd4;
            end
            // a refused item stays on the port unchanged
            if (!inst_valid || inst_allowin) begin
                if (sent < NUM_INSTS && rand_below(100) >= 20) begin
                    inst_valid <= 1'b1;
                    inst       <= make_inst(sent);
                    pc         <= pc_next;
                end else begin
                    inst_valid <= 1'b0;
                end
            end
        end
        while (commit_count < NUM_INSTS) begin
            @(posedge clk);
            commit_ready <= rand_below(100) >= 30;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (accepted_count != NUM_INSTS || commit_count != NUM_INSTS) begin
            $display("ERROR: %0d instructions accepted but %0d committed, expected %0d",
                     accepted_count, commit_count, NUM_INSTS);
            run_errors = run_errors + 1;
        end
        finish_run(1'b0);
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        @(negedge clk);
        $display("ERROR: timeout after %0d cycles with only %0d of %0d instructions committed",
                 cycles, commit_count, NUM_INSTS);
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

//--- src.f
hdl/la_pkg.sv
hdl/la_regfile.sv
hdl/la_alu.sv
hdl/la_decode_stage.sv
hdl/la_execute_stage.sv
hdl/la_result_stage.sv
hdl/la_int_pipe.sv
sim/la_commit_checker.sv
sim/tb_la_int_pipe.sv

//--- Makefile
TOP := tb_la_int_pipe

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f src.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
